// ==== hdl/bmu_pkg.sv ====
// Shared definitions for the pipelined bit-manipulation unit
// Default width, opcode list and result-group tags used by all stages

package bmu_pkg;

    // ------------------------------
    // Widths
    // ------------------------------

    // Default datapath width, power of two and at least 16
    localparam int BMU_XLEN = 32;

    // Number of result groups carried from execute to writeback
    localparam int BMU_GROUPS = 6;

    // ------------------------------
    // Opcodes
    // ------------------------------

    // Register forms only, immediate forms are mapped by the core decoder
    typedef enum logic [4:0] {
        OP_SH1ADD,
        OP_SH2ADD,
        OP_SH3ADD,
        OP_ANDN,
        OP_ORN,
        OP_XNOR,
        OP_CLZ,
        OP_CTZ,
        OP_MAX,
        OP_MAXU,
        OP_MIN,
        OP_MINU,
        OP_SEXTB,
        OP_SEXTH,
        OP_ZEXTH,
        OP_ROL,
        OP_ROR,
        OP_ORCB,
        OP_REV8,
        OP_BCLR,
        OP_BEXT,
        OP_BINV,
        OP_BSET
    } bmu_op_e;

    // ------------------------------
    // Result groups
    // ------------------------------

    // Value doubles as the word index in the execute result bus
    typedef enum logic [2:0] {
        GRP_SHADD,
        GRP_LOGIC,
        GRP_COUNT,
        GRP_COMPARE,
        GRP_EXTEND,
        GRP_PERMUTE
    } bmu_group_e;

endpackage

// ==== hdl/bmu_issue_stage.sv ====
// Issue stage of the bit-manipulation pipeline
// Registers the incoming operation and tags it with its result group

`timescale 1ns/10ps

module bmu_issue_stage #(
    parameter int XLEN = 32
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic [XLEN-1:0]      operand_a_i,
    input  logic [XLEN-1:0]      operand_b_i,
    input  bmu_pkg::bmu_op_e     op_i,
    input  logic                 valid_i,
    output logic [XLEN-1:0]      a_o,
    output logic [XLEN-1:0]      b_o,
    output bmu_pkg::bmu_op_e     op_o,
    output bmu_pkg::bmu_group_e  group_o,
    output logic                 valid_o
);

    // ------------------------------
    // Group decode
    // ------------------------------

    bmu_pkg::bmu_group_e group_d;

    // Only place in the pipeline where the group is derived
    always_comb begin
        case (op_i)
            bmu_pkg::OP_SH1ADD, bmu_pkg::OP_SH2ADD, bmu_pkg::OP_SH3ADD:
                group_d = bmu_pkg::GRP_SHADD;
            bmu_pkg::OP_ANDN, bmu_pkg::OP_ORN, bmu_pkg::OP_XNOR:
                group_d = bmu_pkg::GRP_LOGIC;
            bmu_pkg::OP_CLZ, bmu_pkg::OP_CTZ:
                group_d = bmu_pkg::GRP_COUNT;
            bmu_pkg::OP_MAX, bmu_pkg::OP_MAXU, bmu_pkg::OP_MIN, bmu_pkg::OP_MINU:
                group_d = bmu_pkg::GRP_COMPARE;
            bmu_pkg::OP_SEXTB, bmu_pkg::OP_SEXTH, bmu_pkg::OP_ZEXTH:
                group_d = bmu_pkg::GRP_EXTEND;
            // Rotates, byte and single-bit operations
            default:
                group_d = bmu_pkg::GRP_PERMUTE;
        endcase
    end

    // ------------------------------
    // Stage registers
    // ------------------------------

    // Operands and control payload
    always_ff @(posedge clk_i) begin
        a_o     <= operand_a_i;
        b_o     <= operand_b_i;
        op_o    <= op_i;
        group_o <= group_d;
    end

    // Valid strobe
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

endmodule

// ==== hdl/bmu_zero_counter.sv ====
// Combinational leading or trailing zero counter
// CTZ reuses the leading-zero search on the bit-reversed operand

`timescale 1ns/10ps

module bmu_zero_counter #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]         operand_i,
    input  logic                    trailing_i,
    output logic [$clog2(XLEN):0]   count_o
);

    localparam int IW = $clog2(XLEN);

    logic [XLEN-1:0] reversed;
    logic [XLEN-1:0] search;
    logic [IW-1:0]   lz;
    logic            all_zero;

    // Bit reversal for the trailing count
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            reversed[XLEN-1-i] = operand_i[i];
        end
    end

    assign search = trailing_i ? reversed : operand_i;

    // ------------------------------
    // Leading-zero search
    // ------------------------------

    // Scan upward, the highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i < XLEN; i++) begin
            if (search[i]) begin
                lz = IW'(XLEN - 1 - i);
            end
        end
    end

    assign all_zero = ~|search;

    // All-zero operand counts as XLEN, the MSB alone
    assign count_o = all_zero ? {1'b1, {IW{1'b0}}} : {1'b0, lz};

endmodule

// ==== hdl/bmu_permute_unit.sv ====
// Combinational permute unit of the execute stage
// Rotates, byte operations and single-bit operations on operand a

`timescale 1ns/10ps

module bmu_permute_unit #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]     a_i,
    input  logic [XLEN-1:0]     b_i,
    input  bmu_pkg::bmu_op_e    op_i,
    output logic [XLEN-1:0]     result_o
);

    localparam int IW = $clog2(XLEN);
    localparam int NB = XLEN / 8;

    logic [IW-1:0]     idx;
    logic [XLEN-1:0]   mask;
    logic [2*XLEN-1:0] rol_wide;
    logic [2*XLEN-1:0] ror_wide;
    logic [XLEN-1:0]   orcb_res;
    logic [XLEN-1:0]   rev8_res;

    // Shift amount and bit index from the low bits of b
    assign idx  = b_i[IW-1:0];
    assign mask = {{(XLEN-1){1'b0}}, 1'b1} << idx;

    // ------------------------------
    // Rotates
    // ------------------------------

    // Doubled operand, so a plain shift wraps the bits around
    assign rol_wide = {a_i, a_i} << idx;
    assign ror_wide = {a_i, a_i} >> idx;

    // ------------------------------
    // Byte operations
    // ------------------------------

    always_comb begin
        for (int i = 0; i < NB; i++) begin
            // Any set bit fills the whole byte
            orcb_res[8*i +: 8] = {8{|a_i[8*i +: 8]}};
            // Byte order swap
            rev8_res[8*(NB-1-i) +: 8] = a_i[8*i +: 8];
        end
    end

    // ------------------------------
    // Result select
    // ------------------------------

    always_comb begin
        case (op_i)
            bmu_pkg::OP_ROL:  result_o = rol_wide[2*XLEN-1:XLEN];
            bmu_pkg::OP_ROR:  result_o = ror_wide[XLEN-1:0];
            bmu_pkg::OP_ORCB: result_o = orcb_res;
            bmu_pkg::OP_REV8: result_o = rev8_res;
            bmu_pkg::OP_BCLR: result_o = a_i & ~mask;
            bmu_pkg::OP_BINV: result_o = a_i ^ mask;
            bmu_pkg::OP_BSET: result_o = a_i | mask;
            // Indexed bit lands in bit 0
            bmu_pkg::OP_BEXT: result_o = {{(XLEN-1){1'b0}}, |(a_i & mask)};
            default:          result_o = '0;
        endcase
    end

endmodule

// ==== hdl/bmu_execute_stage.sv ====
// Execute stage of the bit-manipulation pipeline
// Computes one result per group and registers all of them with the group tag
// Writeback then only has to pick a word, keeping the wide mux out of this cycle

`timescale 1ns/10ps

module bmu_execute_stage #(
    parameter int XLEN = 32
) (
    input  logic                                       clk_i,
    input  logic                                       reset_i,
    input  logic [XLEN-1:0]                            a_i,
    input  logic [XLEN-1:0]                            b_i,
    input  bmu_pkg::bmu_op_e                           op_i,
    input  bmu_pkg::bmu_group_e                        group_i,
    input  logic                                       valid_i,
    output logic [bmu_pkg::BMU_GROUPS-1:0][XLEN-1:0]   results_o,
    output bmu_pkg::bmu_group_e                        group_o,
    output logic                                       valid_o
);

    localparam int CW = $clog2(XLEN) + 1;

    logic [1:0]      sh_amt;
    logic [XLEN-1:0] shadd_res;
    logic [XLEN-1:0] logic_res;
    logic [XLEN-1:0] cmp_res;
    logic [XLEN-1:0] ext_res;
    logic [XLEN-1:0] perm_res;
    logic [CW-1:0]   zero_cnt;
    logic            signed_lt;
    logic            unsigned_lt;

    // ------------------------------
    // Shift and add
    // ------------------------------

    always_comb begin
        case (op_i)
            bmu_pkg::OP_SH1ADD: sh_amt = 2'd1;
            bmu_pkg::OP_SH2ADD: sh_amt = 2'd2;
            default:            sh_amt = 2'd3;
        endcase
    end

    assign shadd_res = b_i + (a_i << sh_amt);

    // ------------------------------
    // Negated logic
    // ------------------------------

    always_comb begin
        case (op_i)
            bmu_pkg::OP_ANDN: logic_res = a_i & ~b_i;
            bmu_pkg::OP_ORN:  logic_res = a_i | ~b_i;
            default:          logic_res = ~(a_i ^ b_i);
        endcase
    end

    // ------------------------------
    // Min and max
    // ------------------------------

    // One comparator each for the signed and unsigned orders
    assign signed_lt   = $signed(a_i) < $signed(b_i);
    assign unsigned_lt = a_i < b_i;

    always_comb begin
        case (op_i)
            bmu_pkg::OP_MAX:  cmp_res = signed_lt   ? b_i : a_i;
            bmu_pkg::OP_MAXU: cmp_res = unsigned_lt ? b_i : a_i;
            bmu_pkg::OP_MIN:  cmp_res = signed_lt   ? a_i : b_i;
            default:          cmp_res = unsigned_lt ? a_i : b_i;
        endcase
    end

    // ------------------------------
    // Sign and zero extension
    // ------------------------------

    always_comb begin
        case (op_i)
            bmu_pkg::OP_SEXTB: ext_res = {{(XLEN-8){a_i[7]}}, a_i[7:0]};
            bmu_pkg::OP_SEXTH: ext_res = {{(XLEN-16){a_i[15]}}, a_i[15:0]};
            default:           ext_res = {{(XLEN-16){1'b0}}, a_i[15:0]};
        endcase
    end

    // ------------------------------
    // Helper units
    // ------------------------------

    bmu_zero_counter #(.XLEN(XLEN)) zero_counter_i (
        .operand_i  (a_i),
        .trailing_i (op_i == bmu_pkg::OP_CTZ),
        .count_o    (zero_cnt)
    );

    bmu_permute_unit #(.XLEN(XLEN)) permute_unit_i (
        .a_i      (a_i),
        .b_i      (b_i),
        .op_i     (op_i),
        .result_o (perm_res)
    );

    // ------------------------------
    // Stage registers
    // ------------------------------

    // One word per group, indexed by the group tag value
    always_ff @(posedge clk_i) begin
        results_o[bmu_pkg::GRP_SHADD]   <= shadd_res;
        results_o[bmu_pkg::GRP_LOGIC]   <= logic_res;
        results_o[bmu_pkg::GRP_COUNT]   <= {{(XLEN-CW){1'b0}}, zero_cnt};
        results_o[bmu_pkg::GRP_COMPARE] <= cmp_res;
        results_o[bmu_pkg::GRP_EXTEND]  <= ext_res;
        results_o[bmu_pkg::GRP_PERMUTE] <= perm_res;
        group_o                         <= group_i;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

endmodule

// ==== hdl/bmu_writeback_stage.sv ====
// Writeback stage of the bit-manipulation pipeline
// Picks the word of the tagged group and drives the unit output from a register

`timescale 1ns/10ps

module bmu_writeback_stage #(
    parameter int XLEN = 32
) (
    input  logic                                       clk_i,
    input  logic                                       reset_i,
    input  logic [bmu_pkg::BMU_GROUPS-1:0][XLEN-1:0]   results_i,
    input  bmu_pkg::bmu_group_e                        group_i,
    input  logic                                       valid_i,
    output logic [XLEN-1:0]                            result_o,
    output logic                                       valid_o
);

    logic [XLEN-1:0] result_d;

    // ------------------------------
    // Final select
    // ------------------------------

    // Tag value is the word index, no opcode needed here
    assign result_d = results_i[group_i];

    // ------------------------------
    // Output registers
    // ------------------------------

    always_ff @(posedge clk_i) begin
        result_o <= result_d;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

endmodule

// ==== hdl/bmu_top.sv ====
// Top level of the bit-manipulation unit for a 32-bit RISC-V core
// Three registered stages, one operation per cycle, fixed latency of three

`timescale 1ns/10ps

module bmu_top #(
    parameter int XLEN = bmu_pkg::BMU_XLEN
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic [XLEN-1:0]   operand_a_i,
    input  logic [XLEN-1:0]   operand_b_i,
    input  bmu_pkg::bmu_op_e  op_i,
    input  logic              valid_i,
    output logic [XLEN-1:0]   result_o,
    output logic              valid_o
);

    // ------------------------------
    // Issue to execute
    // ------------------------------

    logic [XLEN-1:0]      iss_a;
    logic [XLEN-1:0]      iss_b;
    bmu_pkg::bmu_op_e     iss_op;
    bmu_pkg::bmu_group_e  iss_group;
    logic                 iss_valid;

    // ------------------------------
    // Execute to writeback
    // ------------------------------

    logic [bmu_pkg::BMU_GROUPS-1:0][XLEN-1:0] exe_results;
    bmu_pkg::bmu_group_e                      exe_group;
    logic                                     exe_valid;

    bmu_issue_stage #(.XLEN(XLEN)) issue_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .op_i        (op_i),
        .valid_i     (valid_i),
        .a_o         (iss_a),
        .b_o         (iss_b),
        .op_o        (iss_op),
        .group_o     (iss_group),
        .valid_o     (iss_valid)
    );

    bmu_execute_stage #(.XLEN(XLEN)) execute_i (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .a_i       (iss_a),
        .b_i       (iss_b),
        .op_i      (iss_op),
        .group_i   (iss_group),
        .valid_i   (iss_valid),
        .results_o (exe_results),
        .group_o   (exe_group),
        .valid_o   (exe_valid)
    );

    bmu_writeback_stage #(.XLEN(XLEN)) writeback_i (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .results_i (exe_results),
        .group_i   (exe_group),
        .valid_i   (exe_valid),
        .result_o  (result_o),
        .valid_o   (valid_o)
    );

endmodule

// ==== dv/bmu_chk.sv ====
// Concurrent assertions on the bit-manipulation unit, bound to its top level
// Covers latency, valid gaps, quiet output after reset and result shape

`timescale 1ns/10ps

module bmu_chk #(
    parameter int XLEN = 32
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  bmu_pkg::bmu_op_e  op_i,
    input  logic              in_valid_i,
    input  logic [XLEN-1:0]   out_result_i,
    input  logic              out_valid_i
);

    // Bits above the width of a zero count must stay clear
    localparam int CW = $clog2(XLEN) + 1;

    // Failure count watched by the testbench
    int unsigned error_count = 0;
    logic        seen_valid;

    // Set by the first accepted operation after reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            seen_valid <= 1'b0;
        end else if (in_valid_i) begin
            seen_valid <= 1'b1;
        end
    end

    // ------------------------------
    // Timing
    // ------------------------------

    assert property (@(posedge clk_i) disable iff (reset_i)
        in_valid_i |-> ##3 out_valid_i)
        else begin
            error_count++;
            $error("valid_i not followed by valid_o 3 cycles later");
        end

    assert property (@(posedge clk_i) disable iff (reset_i)
        !in_valid_i |-> ##3 !out_valid_i)
        else begin
            error_count++;
            $error("Idle input cycle produced valid_o 3 cycles later");
        end

    // Output stays quiet from reset until the first operation
    assert property (@(posedge clk_i) disable iff (reset_i)
        !seen_valid |-> !out_valid_i)
        else begin
            error_count++;
            $error("valid_o high before any operation was issued");
        end

    // ------------------------------
    // Result shape
    // ------------------------------

    assert property (@(posedge clk_i) disable iff (reset_i)
        (in_valid_i && (op_i == bmu_pkg::OP_CLZ || op_i == bmu_pkg::OP_CTZ))
        |-> ##3 ((out_result_i >> CW) == '0))
        else begin
            error_count++;
            $error("Zero count result has bits set above the count");
        end

    assert property (@(posedge clk_i) disable iff (reset_i)
        (in_valid_i && op_i == bmu_pkg::OP_BEXT) |-> ##3 (out_result_i[XLEN-1:1] == '0))
        else begin
            error_count++;
            $error("BEXT result is neither 0 nor 1");
        end

endmodule

bind bmu_top bmu_chk #(.XLEN(XLEN)) chk_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .op_i         (op_i),
    .in_valid_i   (valid_i),
    .out_result_i (result_o),
    .out_valid_i  (valid_o)
);

// ==== dv/bmu_tb.sv ====
// Testbench for the bit-manipulation unit
// Drives directed corner operands and seeded random operations, checks each result
// against a reference model in issue order, and watches the bound checker

`timescale 1ns/10ps

module bmu_tb;

    localparam int  XLEN        = bmu_pkg::BMU_XLEN;
    localparam int  N_OPS       = int'(bmu_pkg::OP_BSET) + 1;
    // Covers reset, about 275 issue and idle cycles and the drain with margin
    localparam int  MAX_CYCLES  = 400;
    localparam real DRIVE_DELAY = 0.5;

    logic             clk_i = 1'b0;
    logic             reset_i;
    logic [XLEN-1:0]  operand_a_i;
    logic [XLEN-1:0]  operand_b_i;
    bmu_pkg::bmu_op_e op_i;
    logic             valid_i;
    logic [XLEN-1:0]  result_o;
    logic             valid_o;

    logic [XLEN-1:0]  expected_q [$];
    logic [XLEN-1:0]  expected;
    logic [XLEN-1:0]  corners [5];
    int               seed = 86;
    int               cycle_count = 0;

    bmu_top dut_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .op_i        (op_i),
        .valid_i     (valid_i),
        .result_o    (result_o),
        .valid_o     (valid_o)
    );

    always #2 clk_i = ~clk_i;

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic logic [XLEN-1:0] leading_zeros(input logic [XLEN-1:0] v);
        int n;
        bit found;
        n = 0;
        found = 1'b0;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (v[i]) found = 1'b1;
            else if (!found) n++;
        end
        return n;
    endfunction

    function automatic logic [XLEN-1:0] trailing_zeros(input logic [XLEN-1:0] v);
        int n;
        bit found;
        n = 0;
        found = 1'b0;
        for (int i = 0; i < XLEN; i++) begin
            if (v[i]) found = 1'b1;
            else if (!found) n++;
        end
        return n;
    endfunction

    function automatic logic [XLEN-1:0] ref_result(input bmu_pkg::bmu_op_e op,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        int idx;
        logic [XLEN-1:0] r;
        // Shift amount or bit index
        idx = int'(b % XLEN);
        r = '0;
        case (op)
            bmu_pkg::OP_SH1ADD: r = b + a * 2;
            bmu_pkg::OP_SH2ADD: r = b + a * 4;
            bmu_pkg::OP_SH3ADD: r = b + a * 8;
            bmu_pkg::OP_ANDN:   r = a & ~b;
            bmu_pkg::OP_ORN:    r = a | ~b;
            bmu_pkg::OP_XNOR:   r = a ~^ b;
            bmu_pkg::OP_CLZ:    r = leading_zeros(a);
            bmu_pkg::OP_CTZ:    r = trailing_zeros(a);
            bmu_pkg::OP_MAX:    r = ($signed(a) > $signed(b)) ? a : b;
            bmu_pkg::OP_MAXU:   r = (a > b) ? a : b;
            bmu_pkg::OP_MIN:    r = ($signed(a) < $signed(b)) ? a : b;
            bmu_pkg::OP_MINU:   r = (a < b) ? a : b;
            bmu_pkg::OP_SEXTB: begin
                for (int i = 0; i < XLEN; i++) r[i] = (i < 8) ? a[i] : a[7];
            end
            bmu_pkg::OP_SEXTH: begin
                for (int i = 0; i < XLEN; i++) r[i] = (i < 16) ? a[i] : a[15];
            end
            bmu_pkg::OP_ZEXTH:  r[15:0] = a[15:0];
            bmu_pkg::OP_ROL: begin
                for (int i = 0; i < XLEN; i++) r[(i + idx) % XLEN] = a[i];
            end
            bmu_pkg::OP_ROR: begin
                for (int i = 0; i < XLEN; i++) r[i] = a[(i + idx) % XLEN];
            end
            bmu_pkg::OP_ORCB: begin
                for (int k = 0; k < XLEN / 8; k++)
                    r[8*k +: 8] = (a[8*k +: 8] != 8'h00) ? 8'hFF : 8'h00;
            end
            bmu_pkg::OP_REV8: begin
                for (int k = 0; k < XLEN / 8; k++) r[8*k +: 8] = a[XLEN-8-8*k +: 8];
            end
            bmu_pkg::OP_BCLR: begin
                r = a;
                r[idx] = 1'b0;
            end
            bmu_pkg::OP_BINV: begin
                r = a;
                r[idx] = ~a[idx];
            end
            bmu_pkg::OP_BSET: begin
                r = a;
                r[idx] = 1'b1;
            end
            bmu_pkg::OP_BEXT:   r[0] = a[idx];
            default:            r = '0;
        endcase
        return r;
    endfunction

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    // One operand in four is a corner value
    function automatic logic [XLEN-1:0] random_operand();
        if ($unsigned($random(seed)) % 4 == 0) return corners[$unsigned($random(seed)) % 5];
        return $random(seed);
    endfunction

    task automatic issue_op(input bmu_pkg::bmu_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        op_i        = op;
        operand_a_i = a;
        operand_b_i = b;
        valid_i     = 1'b1;
        expected_q.push_back(ref_result(op, a, b));
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    // Operands keep moving while idle and must not leak out
    task automatic idle_cycle();
        valid_i     = 1'b0;
        operand_a_i = $random(seed);
        operand_b_i = $random(seed);
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Stopped at first error");
    endtask

    // ------------------------------
    // Checking
    // ------------------------------

    // Outputs are sampled mid-cycle away from the register updates
    always @(negedge clk_i) begin
        if (!reset_i && valid_o) begin
            if (expected_q.size() == 0) begin
                abort_run("valid_o went high with no operation in flight");
            end else begin
                expected = expected_q.pop_front();
                assert (result_o === expected)
                    else abort_run($sformatf(
                        "CHECK FAILED at %0d ns: result_o expected 0x%h, actual 0x%h",
                        $time, expected, result_o));
            end
        end
    end

    always @(negedge clk_i) begin
        if (dut_i.chk_i.error_count != 0) abort_run("A bound checker assertion failed");
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) abort_run("Timeout, the run did not finish in time");
    end

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        reset_i     = 1'b1;
        valid_i     = 1'b0;
        op_i        = bmu_pkg::OP_SH1ADD;
        operand_a_i = '0;
        operand_b_i = '0;
        corners[0]  = 32'h0000_0000;
        corners[1]  = 32'hFFFF_FFFF;
        corners[2]  = 32'h8000_0000;
        corners[3]  = 32'h7FFF_FFFF;
        corners[4]  = 32'h0000_0010;
        repeat (2) @(posedge clk_i);
        #DRIVE_DELAY;
        reset_i = 1'b0;
        // Quiet window between reset and the first operation
        repeat (3) idle_cycle();
        // Every opcode back to back
        for (int k = 0; k < N_OPS; k++)
            issue_op(bmu_pkg::bmu_op_e'(k), random_operand(), random_operand());
        // Each corner as a and as b gives shift amounts 0 and 31
        for (int k = 0; k < N_OPS; k++)
            for (int i = 0; i < 5; i++)
                issue_op(bmu_pkg::bmu_op_e'(k), corners[i], corners[(i + k) % 5]);
        // Opposite signs split the signed and unsigned order
        issue_op(bmu_pkg::OP_MAX, 32'h8000_0000, 32'h1);
        issue_op(bmu_pkg::OP_MAXU, 32'h8000_0000, 32'h1);
        issue_op(bmu_pkg::OP_MIN, 32'h8000_0000, 32'h1);
        issue_op(bmu_pkg::OP_MINU, 32'h8000_0000, 32'h1);
        // Random operations with random gaps
        for (int k = 0; k < 120; k++) begin
            if ($unsigned($random(seed)) % 4 == 0) idle_cycle();
            else issue_op(bmu_pkg::bmu_op_e'($unsigned($random(seed)) % N_OPS),
                          random_operand(), random_operand());
        end
        // Fixed latency of three, so four idle cycles drain the pipeline
        repeat (4) idle_cycle();
        if (expected_q.size() == 0 && dut_i.chk_i.error_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("Results still outstanding or checker errors at end of run");
        end
    end

endmodule

// ==== filelist.f ====
hdl/bmu_pkg.sv
hdl/bmu_issue_stage.sv
hdl/bmu_zero_counter.sv
hdl/bmu_permute_unit.sv
hdl/bmu_execute_stage.sv
hdl/bmu_writeback_stage.sv
hdl/bmu_top.sv
dv/bmu_chk.sv
dv/bmu_tb.sv
